// File: rtl/dcache_params.svh
// geometry and address split macros of the data cache, included by the package and the RTL
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// 2-way set associative, 8 sets
`define DC_SETS 8
`define DC_WAYS 2

// data and address word width
`define DC_WORD_W 32

// tag takes address bits 31:6
`define DC_TAG_W 26

// set index takes address bits 5:3
// bit 2 picks the word in the block, bits 1:0 are byte bits
`define DC_IDX_W 3

`endif

// File: rtl/cachePkg.sv
// shared types of the data cache, referenced by scoped name from every RTL block
`include "dcache_params.svh"

package cachePkg;

  // data and address word
  typedef logic [`DC_WORD_W-1:0] word_t;

  // address bits 31:6
  typedef logic [`DC_TAG_W-1:0] tag_t;

  // address bits 5:3
  typedef logic [`DC_IDX_W-1:0] idx_t;

  // encoded as {valid, dirty}
  // both encodings with valid low count as Invalid
  typedef enum logic [1:0] {
    I      = 2'b00,
    IDIRTY = 2'b01,
    S      = 2'b10,
    M      = 2'b11
  } msi_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    WB0,
    WB1,
    FILL0,
    FILL1,
    UPGRADE,
    FLUSH,
    HALTED
  } ctrlState_t;

endpackage

// File: rtl/dcacheArray.sv
// tag, data, MSI and LRU storage of the data cache, with hit detection and line updates
`include "dcache_params.svh"

module dcacheArray (
  input  logic            CLK,
  input  logic            nRST,
  input  cachePkg::word_t addr,
  input  logic            snoopActive,
  input  cachePkg::idx_t  flushIdx,
  input  logic            flushWay,
  input  logic            flushing,
  input  logic            fillWEN,
  input  logic            fillOffset,
  input  cachePkg::word_t fillData,
  input  logic            storeWEN,
  input  cachePkg::word_t storeData,
  input  logic            cleanLine,
  input  logic            snoopDemote,
  input  logic            snoopInvalidate,
  output logic            hit,
  output cachePkg::msi_t  lineState,
  output cachePkg::tag_t  victimTag,
  output cachePkg::word_t loadWord,
  output cachePkg::word_t evictWord,
  input  logic            evictOffset
);

  // payload storage
  cachePkg::tag_t  tags [`DC_SETS][`DC_WAYS];
  cachePkg::word_t data [`DC_SETS][`DC_WAYS][2];

  // valid and dirty per way, together they form the MSI state
  logic [`DC_WAYS-1:0] valid [`DC_SETS];
  logic [`DC_WAYS-1:0] dirty [`DC_SETS];

  // way to replace next in each set
  logic [`DC_SETS-1:0] lru;

  cachePkg::tag_t      reqTag;
  cachePkg::idx_t      reqIdx;
  cachePkg::idx_t      idx;
  logic                offset;
  logic [`DC_WAYS-1:0] wayMatch;
  logic                hitWay;
  logic                selWay;

  assign reqTag = addr[`DC_WORD_W-1 -: `DC_TAG_W];
  assign reqIdx = addr[3 +: `DC_IDX_W];
  assign offset = addr[2];

  // flush walks the sets by counter
  assign idx = flushing ? flushIdx : reqIdx;

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      wayMatch[w] = valid[idx][w] && (tags[idx][w] == reqTag);
    end
  end

  assign hit    = |wayMatch;
  assign hitWay = wayMatch[1];

  // hit way on a hit, LRU victim on a miss
  assign selWay = flushing ? flushWay : (hit ? hitWay : lru[idx]);

  assign lineState = cachePkg::msi_t'({valid[idx][selWay], dirty[idx][selWay]});
  assign victimTag = tags[idx][selWay];
  assign loadWord  = data[idx][selWay][offset];

  // writeback word, or the snooped word during a snoop
  assign evictWord = data[idx][selWay][evictOffset];

  // store data overrides a fill word written in the same cycle
  always_ff @(posedge CLK) begin
    if (fillWEN) begin
      tags[idx][selWay] <= reqTag;
      data[idx][selWay][fillOffset] <= fillData;
    end
    if (storeWEN) begin
      data[idx][selWay][offset] <= storeData;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '{default: '0};
      dirty <= '{default: '0};
      lru   <= '0;
    end else begin
      // first fill word drops the old line, second makes it valid and clean
      if (fillWEN) begin
        valid[idx][selWay] <= fillOffset;
        dirty[idx][selWay] <= 1'b0;
      end
      // M to S after a writeback or a snoop
      if (cleanLine || snoopDemote) begin
        dirty[idx][selWay] <= 1'b0;
      end
      // any store leaves the line Modified
      if (storeWEN) begin
        dirty[idx][selWay] <= 1'b1;
      end
      if (snoopInvalidate) begin
        valid[idx][selWay] <= 1'b0;
      end
      // the other way becomes the victim
      if (hit && !snoopActive && !flushing) begin
        lru[idx] <= ~hitWay;
      end
    end
  end

endmodule

// File: rtl/dcacheControl.sv
// controller FSM of the data cache, sequencing writebacks, fills, upgrades and the halt flush
`include "dcache_params.svh"

module dcacheControl (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           dmemREN,
  input  logic           dmemWEN,
  input  logic           halt,
  input  logic           hit,
  input  cachePkg::msi_t lineState,
  input  logic           dwait,
  input  logic           ccwait,
  input  logic           snoopEnd,
  input  logic           snoopInv,
  output logic           dREN,
  output logic           dWEN,
  output logic           cctrans,
  output logic           ccwrite,
  output logic           fillWEN,
  output logic           fillOffset,
  output logic           cleanLine,
  output logic           snoopDemote,
  output logic           snoopInvalidate,
  output logic           storeWEN,
  output logic           flushing,
  output cachePkg::idx_t flushIdx,
  output logic           flushWay,
  output logic           dhit,
  output logic           flushed
);

  cachePkg::ctrlState_t state;
  cachePkg::ctrlState_t nextState;

  // set in the upper bits, way in bit 0
  logic [`DC_IDX_W:0] flushCnt;
  logic               flushMode;

  logic quiet;
  logic request;
  logic lineM;
  logic lastWay;
  logic flushStep;

  // no snoop in progress and none just ended
  assign quiet   = !ccwait && !snoopEnd;
  assign request = dmemREN || dmemWEN;
  assign lineM   = (lineState == cachePkg::M);
  assign lastWay = &flushCnt;

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::IDLE: begin
        if (quiet) begin
          if (halt) begin
            nextState = cachePkg::FLUSH;
          end else if (request && !hit) begin
            nextState = lineM ? cachePkg::WB0 : cachePkg::FILL0;
          end else if (dmemWEN && !lineM) begin
            // write hit on a Shared line
            nextState = cachePkg::UPGRADE;
          end
        end
      end
      cachePkg::WB0: begin
        if (!dwait) begin
          nextState = cachePkg::WB1;
        end
      end
      cachePkg::WB1: begin
        if (!dwait) begin
          if (!flushMode) begin
            nextState = cachePkg::FILL0;
          end else if (lastWay) begin
            nextState = cachePkg::HALTED;
          end else begin
            nextState = cachePkg::FLUSH;
          end
        end
      end
      cachePkg::FILL0: begin
        if (!dwait) begin
          nextState = cachePkg::FILL1;
        end
      end
      cachePkg::FILL1, cachePkg::UPGRADE: begin
        if (!dwait) begin
          nextState = cachePkg::IDLE;
        end
      end
      cachePkg::FLUSH: begin
        if (lineM) begin
          nextState = cachePkg::WB0;
        end else if (lastWay) begin
          nextState = cachePkg::HALTED;
        end
      end
      default: begin
        nextState = state;
      end
    endcase
  end

  // next way after a clean way or a finished flush writeback
  assign flushStep = ((state == cachePkg::FLUSH) && !lineM) ||
                     ((state == cachePkg::WB1) && !dwait && flushMode);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= cachePkg::IDLE;
      flushCnt  <= '0;
      flushMode <= 1'b0;
    end else begin
      state <= nextState;
      if ((state == cachePkg::IDLE) && (nextState == cachePkg::FLUSH)) begin
        flushMode <= 1'b1;
      end
      if (flushStep) begin
        flushCnt <= flushCnt + 1'b1;
      end
    end
  end

  assign dREN    = (state == cachePkg::FILL0) || (state == cachePkg::FILL1);
  assign dWEN    = (state == cachePkg::WB0) || (state == cachePkg::WB1);
  assign cctrans = dREN || (state == cachePkg::UPGRADE);

  // write intent on our own request, or a Modified line supplied to a snoop
  assign ccwrite = (cctrans && dmemWEN) || (ccwait && hit && lineM);

  assign fillOffset = (state == cachePkg::WB1) || (state == cachePkg::FILL1);
  assign fillWEN    = dREN && !dwait;
  assign cleanLine  = (state == cachePkg::WB1) && !dwait;

  assign dhit = (state == cachePkg::IDLE) && quiet && hit &&
                (dmemREN || (dmemWEN && lineM));

  // store on a hit, at the end of a write-miss fill, or when an upgrade is granted
  assign storeWEN = (dhit && dmemWEN) ||
                    ((state == cachePkg::FILL1) && !dwait && dmemWEN) ||
                    ((state == cachePkg::UPGRADE) && !dwait && hit);

  // snoop transitions land once the snoop is over
  assign snoopDemote     = snoopEnd && hit && lineM && !snoopInv;
  assign snoopInvalidate = snoopEnd && hit && snoopInv;

  assign flushing = flushMode;
  assign flushIdx = flushCnt[`DC_IDX_W:1];
  assign flushWay = flushCnt[0];
  assign flushed  = (state == cachePkg::HALTED);

endmodule

// File: rtl/snoopTracker.sv
// tracks incoming snoops, flags the cycle after a snoop and whether it invalidates
module snoopTracker (
  input  logic CLK,
  input  logic nRST,
  input  logic ccwait,
  input  logic ccinv,
  output logic snoopEnd,
  output logic snoopInv
);

  logic ccwaitQ;
  logic ccinvQ;
  logic invSeen;

  // first cycle with ccwait low again
  assign snoopEnd = ccwaitQ && !ccwait;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ccwaitQ <= 1'b0;
      ccinvQ  <= 1'b0;
      invSeen <= 1'b0;
    end else begin
      ccwaitQ <= ccwait;
      ccinvQ  <= ccinv;
      // ccinv moving during the snoop marks it as invalidating
      if (ccwait && (ccinv ^ ccinvQ)) begin
        invSeen <= 1'b1;
      end else if (snoopEnd) begin
        invSeen <= 1'b0;
      end
    end
  end

  // held through snoopEnd, cleared after it
  assign snoopInv = invSeen;

endmodule

// File: rtl/dcacheTop.sv
// top level of the coherent data cache, joining storage, controller and snoop tracking
`include "dcache_params.svh"

module dcacheTop (
  input  logic            CLK,
  input  logic            nRST,
  // datapath side
  input  logic            dmemREN,
  input  logic            dmemWEN,
  input  cachePkg::word_t dmemaddr,
  input  cachePkg::word_t dmemstore,
  input  logic            halt,
  output logic            dhit,
  output cachePkg::word_t dmemload,
  output logic            flushed,
  // bus side
  input  logic            dwait,
  input  cachePkg::word_t dload,
  input  logic            ccwait,
  input  logic            ccinv,
  input  cachePkg::word_t ccsnoopaddr,
  output logic            dREN,
  output logic            dWEN,
  output cachePkg::word_t daddr,
  output cachePkg::word_t dstore,
  output logic            cctrans,
  output logic            ccwrite
);

  cachePkg::word_t arrayAddr;
  cachePkg::word_t snoopAddrQ;
  cachePkg::idx_t  wbIdx;
  cachePkg::idx_t  flushIdx;
  cachePkg::tag_t  victimTag;
  cachePkg::msi_t  lineState;
  cachePkg::word_t loadWord;
  cachePkg::word_t evictWord;
  logic            snoopActive;
  logic            snoopEnd;
  logic            snoopInv;
  logic            hit;
  logic            evictOffset;
  logic            fillWEN;
  logic            fillOffset;
  logic            storeWEN;
  logic            cleanLine;
  logic            snoopDemote;
  logic            snoopInvalidate;
  logic            flushing;
  logic            flushWay;

  // snoop address kept for the cycle after ccwait drops, when the line state changes
  always_ff @(posedge CLK) begin
    if (ccwait) begin
      snoopAddrQ <= ccsnoopaddr;
    end
  end

  assign snoopActive = ccwait || snoopEnd;
  assign arrayAddr   = ccwait ? ccsnoopaddr : (snoopEnd ? snoopAddrQ : dmemaddr);

  // snoop replies supply the addressed word
  assign evictOffset = ccwait ? ccsnoopaddr[2] : fillOffset;

  // writebacks use the stored tag, fills use the request address
  assign wbIdx = flushing ? flushIdx : dmemaddr[3 +: `DC_IDX_W];
  assign daddr = dWEN ? {victimTag, wbIdx, fillOffset, 2'b00}
                      : {dmemaddr[`DC_WORD_W-1:3], fillOffset, 2'b00};

  assign dmemload = loadWord;
  assign dstore   = evictWord;

  dcacheArray arrayBlock (
    .CLK             (CLK),
    .nRST            (nRST),
    .addr            (arrayAddr),
    .snoopActive     (snoopActive),
    .flushIdx        (flushIdx),
    .flushWay        (flushWay),
    .flushing        (flushing),
    .fillWEN         (fillWEN),
    .fillOffset      (fillOffset),
    .fillData        (dload),
    .storeWEN        (storeWEN),
    .storeData       (dmemstore),
    .cleanLine       (cleanLine),
    .snoopDemote     (snoopDemote),
    .snoopInvalidate (snoopInvalidate),
    .hit             (hit),
    .lineState       (lineState),
    .victimTag       (victimTag),
    .loadWord        (loadWord),
    .evictWord       (evictWord),
    .evictOffset     (evictOffset)
  );

  dcacheControl ctrlBlock (
    .CLK             (CLK),
    .nRST            (nRST),
    .dmemREN         (dmemREN),
    .dmemWEN         (dmemWEN),
    .halt            (halt),
    .hit             (hit),
    .lineState       (lineState),
    .dwait           (dwait),
    .ccwait          (ccwait),
    .snoopEnd        (snoopEnd),
    .snoopInv        (snoopInv),
    .dREN            (dREN),
    .dWEN            (dWEN),
    .cctrans         (cctrans),
    .ccwrite         (ccwrite),
    .fillWEN         (fillWEN),
    .fillOffset      (fillOffset),
    .cleanLine       (cleanLine),
    .snoopDemote     (snoopDemote),
    .snoopInvalidate (snoopInvalidate),
    .storeWEN        (storeWEN),
    .flushing        (flushing),
    .flushIdx        (flushIdx),
    .flushWay        (flushWay),
    .dhit            (dhit),
    .flushed         (flushed)
  );

  snoopTracker snoopBlock (
    .CLK      (CLK),
    .nRST     (nRST),
    .ccwait   (ccwait),
    .ccinv    (ccinv),
    .snoopEnd (snoopEnd),
    .snoopInv (snoopInv)
  );

endmodule

// File: verification/dcache_props.sv
// bus and datapath rules of the data cache, bound into the top level as assertions
module dcache_props (
  input logic            CLK,
  input logic            nRST,
  input logic            dmemREN,
  input logic            dmemWEN,
  input logic            dREN,
  input logic            dWEN,
  input logic            dwait,
  input cachePkg::word_t daddr,
  input logic            cctrans,
  input logic            ccwait,
  input logic            dhit
);

  // a memory request and its address stay put until dwait drops
  assert property (@(posedge CLK) disable iff (!nRST)
                   (dREN || dWEN) && dwait |=> $stable({dREN, dWEN, daddr}))
    else $error("memory request changed while dwait is high");

  // bus transactions only while the datapath holds a request
  assert property (@(posedge CLK) disable iff (!nRST) cctrans |-> (dmemREN || dmemWEN))
    else $error("cctrans is high without a datapath request");

  // no hit while a snoop owns the array, nor in the cycle after it
  assert property (@(posedge CLK) disable iff (!nRST) (ccwait || $past(ccwait)) |-> !dhit)
    else $error("dhit is high during or right after a snoop");

endmodule

bind dcacheTop dcache_props propsInst (
  .CLK     (CLK),
  .nRST    (nRST),
  .dmemREN (dmemREN),
  .dmemWEN (dmemWEN),
  .dREN    (dREN),
  .dWEN    (dWEN),
  .dwait   (dwait),
  .daddr   (daddr),
  .cctrans (cctrans),
  .ccwait  (ccwait),
  .dhit    (dhit)
);

// File: verification/dcacheChecker.sv
// watches the data cache ports, keeps a mirror of written-back words and checks each test
module dcacheChecker (
  input  logic            CLK,
  input  logic            dhit,
  input  cachePkg::word_t dmemload,
  input  logic            flushed,
  input  logic            dREN,
  input  logic            dWEN,
  input  logic            dwait,
  input  cachePkg::word_t daddr,
  input  cachePkg::word_t dstore,
  input  logic            cctrans,
  input  logic            ccwrite,
  input  logic            ccwait,
  input  logic            testStart,
  input  logic            testDone,
  input  int              testNum,
  input  logic [31:0]     testOp,
  input  logic [31:0]     testAddr,
  input  logic [31:0]     testData,
  input  logic [31:0]     testExpect,
  output int              testsRun,
  output int              errorCount
);

  cachePkg::word_t mirror [cachePkg::word_t];
  cachePkg::word_t loaded;
  cachePkg::word_t supplied;
  logic sawFill;
  logic sawUpgrade;
  logic sawHit;
  logic sawSupply;
  logic bad;

  initial begin
    testsRun   = 0;
    errorCount = 0;
  end

  always @(posedge CLK) begin
    if (testStart) begin
      sawFill    = 1'b0;
      sawUpgrade = 1'b0;
      sawHit     = 1'b0;
      sawSupply  = 1'b0;
    end
    if (dREN) sawFill = 1'b1;
    // write intent on the bus before the hit
    if (cctrans && ccwrite && !sawHit) sawUpgrade = 1'b1;
    if (dhit && !sawHit) begin
      sawHit = 1'b1;
      loaded = dmemload;
    end
    if (ccwait && ccwrite) begin
      sawSupply = 1'b1;
      supplied  = dstore;
    end
    // word transferred to memory this cycle
    if (dWEN && !dwait) mirror[daddr] = dstore;
    if (testDone) begin
      bad = 1'b0;
      case (testOp)
        1, 2, 9: begin
          if (loaded !== testExpect) begin
            $display("mismatch dmemload addr %h: got %h, expected %h", testAddr, loaded,
                     testExpect);
            bad = 1'b1;
          end
          if (testOp == 2 && sawFill) begin
            $display("read of %h should hit but the cache fetched from memory", testAddr);
            bad = 1'b1;
          end
          if (testOp == 9 && !sawFill) begin
            $display("read of %h should miss but no memory fetch was seen", testAddr);
            bad = 1'b1;
          end
        end
        4: begin
          if (!sawUpgrade) begin
            $display("write to shared line %h raised no upgrade before dhit", testAddr);
            bad = 1'b1;
          end
        end
        5, 6: begin
          if (testData != 0 && !sawSupply) begin
            $display("snoop of modified line %h did not raise ccwrite", testAddr);
            bad = 1'b1;
          end else if (testData != 0 && supplied !== testExpect) begin
            $display("mismatch dstore addr %h: got %h, expected %h", testAddr, supplied,
                     testExpect);
            bad = 1'b1;
          end else if (testData == 0 && sawSupply) begin
            $display("snoop of clean line %h raised ccwrite", testAddr);
            bad = 1'b1;
          end
        end
        7: begin
          if (!flushed) begin
            $display("flushed is low at the end of the halt");
            bad = 1'b1;
          end
        end
        8: begin
          if (!mirror.exists(testAddr)) begin
            $display("no writeback was seen for address %h", testAddr);
            bad = 1'b1;
          end else if (mirror[testAddr] !== testExpect) begin
            $display("mismatch dstore written to addr %h: got %h, expected %h", testAddr,
                     mirror[testAddr], testExpect);
            bad = 1'b1;
          end
        end
        default: ;
      endcase
      testsRun++;
      if (bad) errorCount++;
      $display("test %0d op %0d addr %h: %s", testNum, testOp, testAddr, bad ? "error" : "ok");
    end
  end

endmodule

// File: verification/dcacheTb.sv
// testbench of the data cache, runs the stimulus file against a memory model and remote snoops
module dcacheTb;

  localparam int memLat    = 2;
  localparam int maxRows   = 64;
  localparam int waitLimit = 300;
  localparam logic [31:0] memPattern = 32'h50d9af26;

  logic CLK = 1'b0;
  logic nRST;
  logic dmemREN;
  logic dmemWEN;
  logic halt;
  logic dwait;
  logic ccwait;
  logic ccinv;
  logic dhit;
  logic flushed;
  logic dREN;
  logic dWEN;
  logic cctrans;
  logic ccwrite;
  cachePkg::word_t dmemaddr;
  cachePkg::word_t dmemstore;
  cachePkg::word_t dload;
  cachePkg::word_t ccsnoopaddr;
  cachePkg::word_t dmemload;
  cachePkg::word_t daddr;
  cachePkg::word_t dstore;

  logic [31:0] stim [0:maxRows*4-1];
  cachePkg::word_t memory [cachePkg::word_t];
  int memCnt;

  logic testStart;
  logic testDone;
  logic timedOut;
  int testNum;
  logic [31:0] testOp;
  logic [31:0] testAddr;
  logic [31:0] testData;
  logic [31:0] testExpect;
  int testsRun;
  int errorCount;

  always #10 CLK = ~CLK;

  dcacheTop dcacheTop_inst (.*);

  dcacheChecker resultCheck (.*);

  function automatic cachePkg::word_t memRead(cachePkg::word_t a);
    return memory.exists(a) ? memory[a] : (a ^ memPattern);
  endfunction

  // one word per memLat cycles, upgrades are granted the same way
  always @(negedge CLK) begin
    if (!nRST || !dwait) begin
      dwait  = 1'b1;
      memCnt = 0;
    end else if (dREN || dWEN || cctrans) begin
      if (memCnt == memLat - 1) begin
        dwait = 1'b0;
        dload = memRead(daddr);
        if (dWEN) memory[daddr] = dstore;
      end else begin
        memCnt++;
      end
    end
  end

  task automatic reportTimeout(input string what);
    $display("timeout waiting for %s in test %0d", what, testNum);
    timedOut = 1'b1;
  endtask

  task automatic waitForHit();
    logic seen;
    seen = 1'b0;
    for (int c = 0; c < waitLimit && !seen; c++) begin
      @(posedge CLK);
      seen = dhit;
    end
    if (!seen) reportTimeout("dhit");
  endtask

  task automatic waitForFlushed();
    logic seen;
    seen = 1'b0;
    for (int c = 0; c < waitLimit && !seen; c++) begin
      @(posedge CLK);
      seen = flushed;
    end
    if (!seen) reportTimeout("flushed");
  endtask

  task automatic runRow(input int row);
    testNum    = row + 1;
    testOp     = stim[row*4];
    testAddr   = stim[row*4+1];
    testData   = stim[row*4+2];
    testExpect = stim[row*4+3];
    // one-cycle pulse clears the per-test flags of the checker
    testStart  = 1'b1;
    @(negedge CLK);
    testStart  = 1'b0;
    case (testOp)
      1, 2, 9: begin
        dmemREN  = 1'b1;
        dmemaddr = testAddr;
        waitForHit();
      end
      3, 4: begin
        dmemWEN   = 1'b1;
        dmemaddr  = testAddr;
        dmemstore = testData;
        waitForHit();
      end
      5, 6: begin
        ccwait      = 1'b1;
        ccsnoopaddr = testAddr;
        ccinv       = (testOp == 6);
        // read of the snooped line stays stalled through the snoop end cycle
        dmemREN     = 1'b1;
        dmemaddr    = testAddr;
        repeat (2) @(negedge CLK);
        ccwait = 1'b0;
        ccinv  = 1'b0;
        // snoop end cycle applies the state change
        @(negedge CLK);
        dmemREN = 1'b0;
        @(posedge CLK);
      end
      7: begin
        halt = 1'b1;
        waitForFlushed();
      end
      default: @(posedge CLK);
    endcase
    @(negedge CLK);
    dmemREN  = 1'b0;
    dmemWEN  = 1'b0;
    testDone = 1'b1;
    @(negedge CLK);
    testDone = 1'b0;
  endtask

  initial begin
    nRST        = 1'b0;
    dmemREN     = 1'b0;
    dmemWEN     = 1'b0;
    dmemaddr    = '0;
    dmemstore   = '0;
    halt        = 1'b0;
    dwait       = 1'b1;
    dload       = '0;
    ccwait      = 1'b0;
    ccinv       = 1'b0;
    ccsnoopaddr = '0;
    memCnt      = 0;
    testStart   = 1'b0;
    testDone    = 1'b0;
    timedOut    = 1'b0;
    testNum     = 0;
    testOp      = '0;
    testAddr    = '0;
    testData    = '0;
    testExpect  = '0;
    for (int i = 0; i < maxRows*4; i++) stim[i] = '0;
    $readmemh("verification/dcache_stimulus.txt", stim);
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    for (int row = 0; row < maxRows && stim[row*4] != 0 && !timedOut; row++) begin
      runRow(row);
    end
    $display("tests %0d, errors %0d", testsRun, errorCount);
    if (errorCount == 0 && testsRun > 0 && !timedOut) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verification/dcache_stimulus.txt
// columns: op address data expected, all hex; a row of zeros ends the list
// op 1 read, 2 read hit, 9 read miss, 3 write, 4 write upgrade, 5 snoop, 6 snoopInv, 7 halt, 8 memory
00000009 00000100 00000000 50d9ae26
00000002 00000100 00000000 50d9ae26
00000003 00000208 12345678 00000000
00000002 00000208 00000000 12345678
00000003 00000010 aaaa0001 00000000
00000003 00000050 bbbb0002 00000000
00000009 00000090 00000000 50d9afb6
00000008 00000010 00000000 aaaa0001
00000008 00000014 00000000 50d9af32
00000002 00000050 00000000 bbbb0002
00000005 00000208 00000001 12345678
00000004 00000208 0badf00d 00000000
00000002 00000208 00000000 0badf00d
00000006 00000100 00000000 00000000
00000009 00000100 00000000 50d9ae26
00000007 00000000 00000000 00000000
00000008 00000208 00000000 0badf00d
00000008 0000020c 00000000 50d9ad2a
00000008 00000050 00000000 bbbb0002
00000008 00000054 00000000 50d9af72
00000000 00000000 00000000 00000000

// File: list.f
+incdir+rtl
rtl/cachePkg.sv
rtl/dcacheArray.sv
rtl/dcacheControl.sv
rtl/snoopTracker.sv
rtl/dcacheTop.sv
verification/dcache_props.sv
verification/dcacheChecker.sv
verification/dcacheTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module dcacheTb -f list.f -o dcacheSim &&
./obj_dir/dcacheSim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }
